/* logic/ahb_data_phase.sv */
/*
  Data-phase tracking for the shared slave.
  All registers advance only when o_hreadymux is high.
  o_hreadymux is combinational from i_hreadyout.
  HWDATA is zero until a port has owned an address phase.
*/
`timescale 1ns/100ps

module ahb_data_phase
(
  input  logic              HCLK,            // AHB clock
  input  logic              HRESETn,         // Sync reset, active low
  input  mtx_pkg::port_id_t i_addr_in_port,  // Address-phase owner
  input  logic              i_no_port,       // No address-phase owner
  input  logic              i_hsel,          // Routed sel
  input  logic              i_hreadyout,     // Slave HREADYOUT
  input  ahb_pkg::wdata_t   i_wdata1,        // Port 1 write data
  input  ahb_pkg::wdata_t   i_wdata2,        // Port 2 write data
  input  ahb_pkg::wdata_t   i_wdata3,        // Port 3 write data
  output ahb_pkg::wdata_t   o_hwdata,        // Routed write data
  output logic              o_hreadymux      // HREADYMUXM
);

  mtx_pkg::port_id_t data_port_q;   // Owner of the data phase
  logic              data_valid_q;  // Data phase has an owner
  logic              slave_sel_q;   // Slave selected in last accepted phase

  // ----------------------------------------
  // Data-phase registers
  // ----------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port_q  <= '0;
      data_valid_q <= 1'b0;
      slave_sel_q  <= 1'b0;
    end
    else if (o_hreadymux)                   // Hold through wait states
    begin
      data_port_q  <= i_addr_in_port;
      data_valid_q <= !i_no_port;
      slave_sel_q  <= i_hsel;
    end
  end

  // Slave's ready only counts when it owns the data phase
  assign o_hreadymux = slave_sel_q ? i_hreadyout : 1'b1;

  ahb_port_mux #(.payload_t(ahb_pkg::wdata_t)) u_wdata_mux
  (
    .i_port  (data_port_q),
    .i_valid (data_valid_q),
    .i_pl1   (i_wdata1),
    .i_pl2   (i_wdata2),
    .i_pl3   (i_wdata3),
    .o_pl    (o_hwdata)
  );

endmodule

/* logic/ahb_mtx_output_stage.sv */
/*
  AHB bus matrix output stage: three input ports onto one slave.
  Address outputs are combinational from the registered grant.
  HWDATA follows the previous accepted address phase.
  No user sideband and no fixed-length burst counting.
*/
`timescale 1ns/100ps
`include "ahb_mtx_settings.svh"

module ahb_mtx_output_stage
(
  input  logic                   HCLK,             // AHB clock
  input  logic                   HRESETn,          // Sync reset, active low

  // ----------------------------------------
  // Input ports
  // ----------------------------------------
  input  logic                   i_sel_op1,
  input  logic [`AHB_ADDR_W-1:0] i_addr_op1,
  input  ahb_pkg::htrans_t       i_trans_op1,
  input  logic                   i_write_op1,
  input  ahb_pkg::hsize_t        i_size_op1,
  input  ahb_pkg::hburst_t       i_burst_op1,
  input  logic [3:0]             i_prot_op1,
  input  logic [3:0]             i_master_op1,
  input  logic                   i_mastlock_op1,
  input  ahb_pkg::wdata_t        i_wdata_op1,
  input  logic                   i_held_tran_op1,  // Port 1 has a transfer waiting

  input  logic                   i_sel_op2,
  input  logic [`AHB_ADDR_W-1:0] i_addr_op2,
  input  ahb_pkg::htrans_t       i_trans_op2,
  input  logic                   i_write_op2,
  input  ahb_pkg::hsize_t        i_size_op2,
  input  ahb_pkg::hburst_t       i_burst_op2,
  input  logic [3:0]             i_prot_op2,
  input  logic [3:0]             i_master_op2,
  input  logic                   i_mastlock_op2,
  input  ahb_pkg::wdata_t        i_wdata_op2,
  input  logic                   i_held_tran_op2,  // Port 2 has a transfer waiting

  input  logic                   i_sel_op3,
  input  logic [`AHB_ADDR_W-1:0] i_addr_op3,
  input  ahb_pkg::htrans_t       i_trans_op3,
  input  logic                   i_write_op3,
  input  ahb_pkg::hsize_t        i_size_op3,
  input  ahb_pkg::hburst_t       i_burst_op3,
  input  logic [3:0]             i_prot_op3,
  input  logic [3:0]             i_master_op3,
  input  logic                   i_mastlock_op3,
  input  ahb_pkg::wdata_t        i_wdata_op3,
  input  logic                   i_held_tran_op3,  // Port 3 has a transfer waiting

  input  logic                   i_hreadyoutm,     // Slave HREADYOUT

  output logic                   o_active_op1,     // Port 1 owns address phase
  output logic                   o_active_op2,
  output logic                   o_active_op3,

  // ----------------------------------------
  // Slave side
  // ----------------------------------------
  output logic                   o_hselm,
  output logic [`AHB_ADDR_W-1:0] o_haddrm,
  output ahb_pkg::htrans_t       o_htransm,
  output logic                   o_hwritem,
  output ahb_pkg::hsize_t        o_hsizem,
  output ahb_pkg::hburst_t       o_hburstm,
  output logic [3:0]             o_hprotm,
  output logic [3:0]             o_hmasterm,
  output logic                   o_hmastlockm,
  output logic                   o_hreadymuxm,     // Ready back to the ports
  output ahb_pkg::wdata_t        o_hwdatam
);

  ahb_pkg::addr_ctrl_t pl_op1;         // Port 1 address payload
  ahb_pkg::addr_ctrl_t pl_op2;         // Port 2 address payload
  ahb_pkg::addr_ctrl_t pl_op3;         // Port 3 address payload
  ahb_pkg::addr_ctrl_t pl_sel;         // Routed address payload
  mtx_pkg::port_id_t   addr_in_port;   // Address-phase owner
  logic                no_port;        // No owner
  logic                hreadymux;      // Internal HREADYMUXM
  logic                req_port1;
  logic                req_port2;
  logic                req_port3;

  // Request only with a pending transfer aimed at this slave
  assign req_port1 = i_held_tran_op1 & i_sel_op1;
  assign req_port2 = i_held_tran_op2 & i_sel_op2;
  assign req_port3 = i_held_tran_op3 & i_sel_op3;

  // Pack each port's address phase
  assign pl_op1 = '{sel: i_sel_op1, addr: i_addr_op1, trans: i_trans_op1,
                    write: i_write_op1, size: i_size_op1, burst: i_burst_op1,
                    prot: i_prot_op1, master: i_master_op1,
                    mastlock: i_mastlock_op1};
  assign pl_op2 = '{sel: i_sel_op2, addr: i_addr_op2, trans: i_trans_op2,
                    write: i_write_op2, size: i_size_op2, burst: i_burst_op2,
                    prot: i_prot_op2, master: i_master_op2,
                    mastlock: i_mastlock_op2};
  assign pl_op3 = '{sel: i_sel_op3, addr: i_addr_op3, trans: i_trans_op3,
                    write: i_write_op3, size: i_size_op3, burst: i_burst_op3,
                    prot: i_prot_op3, master: i_master_op3,
                    mastlock: i_mastlock_op3};

  // ----------------------------------------
  // Arbitration and address routing
  // ----------------------------------------
  ahb_out_arbiter u_arb
  (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_req_port1    (req_port1),
    .i_req_port2    (req_port2),
    .i_req_port3    (req_port3),
    .i_hready       (hreadymux),
    .i_hsel         (pl_sel.sel),
    .i_htrans       (pl_sel.trans),
    .i_hmastlock    (pl_sel.mastlock),
    .o_addr_in_port (addr_in_port),
    .o_no_port      (no_port)
  );

  ahb_port_mux #(.payload_t(ahb_pkg::addr_ctrl_t)) u_addr_mux
  (
    .i_port  (addr_in_port),
    .i_valid (!no_port),             // All zero with no owner
    .i_pl1   (pl_op1),
    .i_pl2   (pl_op2),
    .i_pl3   (pl_op3),
    .o_pl    (pl_sel)
  );

  ahb_data_phase u_data
  (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .i_addr_in_port (addr_in_port),
    .i_no_port      (no_port),
    .i_hsel         (pl_sel.sel),
    .i_hreadyout    (i_hreadyoutm),
    .i_wdata1       (i_wdata_op1),
    .i_wdata2       (i_wdata_op2),
    .i_wdata3       (i_wdata_op3),
    .o_hwdata       (o_hwdatam),
    .o_hreadymux    (hreadymux)
  );

  // Active decode, one-hot when owned
  always_comb
  begin
    o_active_op1 = 1'b0;
    o_active_op2 = 1'b0;
    o_active_op3 = 1'b0;
    if (!no_port)
    begin
      case (addr_in_port)
        mtx_pkg::PORT_1 : o_active_op1 = 1'b1;
        mtx_pkg::PORT_2 : o_active_op2 = 1'b1;
        mtx_pkg::PORT_3 : o_active_op3 = 1'b1;
        default :
        begin
          o_active_op1 = 1'bx;       // Bad grant code
          o_active_op2 = 1'bx;
          o_active_op3 = 1'bx;
        end
      endcase
    end
  end

  // Unpack onto the slave
  assign o_hselm      = pl_sel.sel;
  assign o_haddrm     = pl_sel.addr;
  assign o_htransm    = pl_sel.trans;
  assign o_hwritem    = pl_sel.write;
  assign o_hsizem     = pl_sel.size;
  assign o_hburstm    = pl_sel.burst;
  assign o_hprotm     = pl_sel.prot;
  assign o_hmasterm   = pl_sel.master;
  assign o_hmastlockm = pl_sel.mastlock;
  assign o_hreadymuxm = hreadymux;

endmodule

/* logic/ahb_mtx_settings.svh */
/*
  Global sizes for the AHB matrix output stage.
  MTX_NUM_PORTS only sizes the port code and the arbiter loop. The muxes
  are written for exactly three ports, so changing it breaks the design.
*/
`ifndef AHB_MTX_SETTINGS_SVH
`define AHB_MTX_SETTINGS_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------
`define AHB_ADDR_W 32                     // HADDR width
`define AHB_DATA_W 32                     // HWDATA width

// ----------------------------------------
// Matrix shape
// ----------------------------------------
`define MTX_NUM_PORTS 3                   // Input ports into this stage

`endif

/* logic/ahb_out_arbiter.sv */
/*
  Round-robin arbiter for one shared AHB slave.
  Grant and no_port are registered and move only when i_hready is high.
  A burst keeps the grant only while the owner shows SEQ or BUSY; there
  is no beat counter. A locked owner keeps it until HMASTLOCK falls.
*/
`timescale 1ns/100ps
`include "ahb_mtx_settings.svh"

module ahb_out_arbiter
(
  input  logic              HCLK,            // AHB clock
  input  logic              HRESETn,         // Sync reset, active low
  input  logic              i_req_port1,     // Port 1 wants the slave
  input  logic              i_req_port2,     // Port 2 wants the slave
  input  logic              i_req_port3,     // Port 3 wants the slave
  input  logic              i_hready,        // HREADYMUXM
  input  logic              i_hsel,          // Routed sel of the owner
  input  ahb_pkg::htrans_t  i_htrans,        // Routed trans of the owner
  input  logic              i_hmastlock,     // Routed mastlock of the owner
  output mtx_pkg::port_id_t o_addr_in_port,  // Address-phase owner
  output logic              o_no_port        // Nobody owns the slave
);

  // ----------------------------------------
  // State
  // ----------------------------------------
  mtx_pkg::port_id_t grant_q;       // Owner, also the last grant for rotation
  logic              no_port_q;     // No owner this address phase
  logic              hsel_lock;     // Locked sequence already started here
  logic              hsel_lock_nxt; // Next hsel_lock
  logic              lock_arb;      // Mastlock as seen by the arbiter
  logic              hold;          // Keep the current owner
  logic [3:0]        req_vec;       // Requests indexed by port code
  mtx_pkg::port_id_t cand;          // Port being tried in the rotation
  mtx_pkg::port_id_t pick_port;     // Rotation result
  logic              pick_none;     // No request seen

  // Next code in the order 1, 2, 3, 1
  function automatic mtx_pkg::port_id_t next_id(input mtx_pkg::port_id_t p);
    if (p == mtx_pkg::PORT_3)
      return mtx_pkg::PORT_1;
    else
      return mtx_pkg::port_id_t'(p + 1'b1);
  endfunction

  assign req_vec = {i_req_port3, i_req_port2, i_req_port1, 1'b0}; // Code 0 never asks

  // ----------------------------------------
  // Lock tracking
  // ----------------------------------------
  // A master may address another slave inside a locked sequence, so sel
  // drops while mastlock stays high. The held flag keeps the lock alive.
  assign hsel_lock_nxt = (i_hsel & i_htrans[1] & i_hmastlock) ? 1'b1 :  // Locked active beat
                         (!i_hmastlock)                        ? 1'b0 :  // Sequence over
                         hsel_lock;

  assign lock_arb = i_hmastlock & (i_hsel | hsel_lock);  // Mastlock only if ours

  // Owner keeps the slave through locks and burst continuation
  assign hold = !no_port_q &
                (lock_arb || (i_htrans == ahb_pkg::SEQ) || (i_htrans == ahb_pkg::BUSY));

  // ----------------------------------------
  // Rotation
  // ----------------------------------------
  always_comb
  begin
    pick_port = grant_q;            // Keep last grant when idle
    pick_none = 1'b1;
    cand      = next_id(grant_q);   // Start just after the last owner
    for (int i = 0; i < `MTX_NUM_PORTS; i++)
    begin
      if (pick_none && req_vec[cand])
      begin
        pick_port = cand;
        pick_none = 1'b0;
      end
      cand = next_id(cand);
    end
  end

  // ----------------------------------------
  // Registers
  // ----------------------------------------
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      grant_q   <= mtx_pkg::PORT_FIRST;     // Port 1 wins first
      no_port_q <= 1'b1;
      hsel_lock <= 1'b0;
    end
    else if (i_hready)                      // Frozen under wait states
    begin
      hsel_lock <= hsel_lock_nxt;
      if (!hold)
      begin
        grant_q   <= pick_port;
        no_port_q <= pick_none;
      end
    end
  end

  assign o_addr_in_port = grant_q;
  assign o_no_port      = no_port_q;

endmodule

/* logic/ahb_pkg.sv */
/*
  AHB field types shared by the output stage.
  The user sideband buses (HAUSER, HWUSER) are not carried.
  addr_ctrl_t is the full address-phase payload of one port.
*/
`include "ahb_mtx_settings.svh"

package ahb_pkg;

  // ----------------------------------------
  // Transfer fields
  // ----------------------------------------
  typedef enum logic [1:0]
  {
    IDLE   = 2'b00,                       // No transfer
    BUSY   = 2'b01,                       // Burst pause, keeps ownership
    NONSEQ = 2'b10,                       // First or single beat
    SEQ    = 2'b11                        // Following burst beat
  } htrans_t;

  typedef logic [2:0] hsize_t;            // Bytes = 2**size
  typedef logic [2:0] hburst_t;           // Burst type, not counted here

  // ----------------------------------------
  // Payloads
  // ----------------------------------------
  typedef logic [`AHB_DATA_W-1:0] wdata_t;   // Data-phase payload

  typedef struct packed
  {
    logic                   sel;          // Port HSEL for this slave
    logic [`AHB_ADDR_W-1:0] addr;         // HADDR
    htrans_t                trans;        // HTRANS
    logic                   write;        // HWRITE
    hsize_t                 size;         // HSIZE
    hburst_t                burst;        // HBURST
    logic [3:0]             prot;         // HPROT
    logic [3:0]             master;       // HMASTER
    logic                   mastlock;     // HMASTLOCK
  } addr_ctrl_t;

endpackage

/* logic/ahb_port_mux.sv */
/*
  Three-way payload select by port code.
  Outputs zero when i_valid is low. Code 0 drives X so a bad
  decode shows up in simulation.
*/
`timescale 1ns/100ps

module ahb_port_mux
#(
  parameter type payload_t = logic        // Struct or word being routed
)
(
  input  mtx_pkg::port_id_t i_port,       // Selected port code
  input  logic              i_valid,      // Select is meaningful
  input  payload_t          i_pl1,        // Port 1 payload
  input  payload_t          i_pl2,        // Port 2 payload
  input  payload_t          i_pl3,        // Port 3 payload
  output payload_t          o_pl          // Routed payload
);

  always_comb
  begin
    if (!i_valid)
      o_pl = '0;                          // Quiet bus with no owner
    else
    begin
      case (i_port)
        mtx_pkg::PORT_1 : o_pl = i_pl1;
        mtx_pkg::PORT_2 : o_pl = i_pl2;
        mtx_pkg::PORT_3 : o_pl = i_pl3;
        default         : o_pl = 'x;      // Code 0 never selected
      endcase
    end
  end

endmodule

/* logic/mtx_pkg.sv */
/*
  Port numbering for the matrix output stage.
  Code 0 is never a valid port and decodes to X in the muxes.
*/
`include "ahb_mtx_settings.svh"

package mtx_pkg;

  // Room for ports 1..N plus the invalid code 0
  localparam int unsigned PORT_ID_W = $clog2(`MTX_NUM_PORTS + 1);

  typedef logic [PORT_ID_W-1:0] port_id_t;

  // ----------------------------------------
  // Port codes
  // ----------------------------------------
  localparam port_id_t PORT_1 = port_id_t'(1);   // Input port 1
  localparam port_id_t PORT_2 = port_id_t'(2);   // Input port 2
  localparam port_id_t PORT_3 = port_id_t'(3);   // Input port 3

  // Reset value of the last grant, so the rotation starts at port 1
  localparam port_id_t PORT_FIRST = PORT_3;

endpackage

/* run.sh */
#!/bin/sh
# Build and run the output stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -f tb.f --top-module tb_output_stage \
     -Mdir obj_dir -o sim_tb; then
  echo "Build failed"
  exit 1
fi

if ! ./obj_dir/sim_tb > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi

cat sim.log

if grep -q "^Test passed$" sim.log; then
  exit 0
fi
exit 1

/* tb.f */
+incdir+logic
logic/ahb_pkg.sv
logic/mtx_pkg.sv
logic/ahb_port_mux.sv
logic/ahb_out_arbiter.sv
logic/ahb_data_phase.sv
logic/ahb_mtx_output_stage.sv
testbench/ahb_mtx_asserts.sv
testbench/tb_output_stage.sv

/* testbench/ahb_mtx_asserts.sv */
/*
  Protocol checks bound onto every ahb_mtx_output_stage instance.
  Checks are off while HRESETn is low.
  HWDATA stability assumes the ports hold their write data in wait states.
*/
`timescale 1ns/100ps

module ahb_mtx_asserts
(
  input logic             HCLK,          // AHB clock
  input logic             HRESETn,       // Sync reset, active low
  input logic             i_active_op1,  // Port 1 owns the address phase
  input logic             i_active_op2,
  input logic             i_active_op3,
  input logic             i_hselm,       // Routed HSEL
  input ahb_pkg::htrans_t i_htransm,     // Routed HTRANS
  input logic             i_hreadymuxm,  // HREADYMUXM
  input ahb_pkg::wdata_t  i_hwdatam      // Routed HWDATA
);

  // Never two owners at once
  one_owner : assert property (@(posedge HCLK) disable iff (!HRESETn)
    $onehot0({i_active_op3, i_active_op2, i_active_op1}))
    else $error("more than one active output is high");

  // Write data frozen across a wait state
  wdata_hold : assert property (@(posedge HCLK) disable iff (!HRESETn)
    !i_hreadymuxm |=> $stable(i_hwdatam))
    else $error("HWDATAM changed while HREADYMUXM was low");

  // Quiet bus when no active output shows an owner
  idle_unowned : assert property (@(posedge HCLK) disable iff (!HRESETn)
    (!(i_active_op1 || i_active_op2 || i_active_op3) && !i_hselm)
      |-> (i_htransm == ahb_pkg::IDLE))
    else $error("HTRANSM not IDLE with no port granted");

endmodule

bind ahb_mtx_output_stage ahb_mtx_asserts u_asserts
(
  .HCLK         (HCLK),
  .HRESETn      (HRESETn),
  .i_active_op1 (o_active_op1),
  .i_active_op2 (o_active_op2),
  .i_active_op3 (o_active_op3),
  .i_hselm      (o_hselm),
  .i_htransm    (o_htransm),
  .i_hreadymuxm (o_hreadymuxm),
  .i_hwdatam    (o_hwdatam)
);

/* testbench/tb_output_stage.sv */
/*
  Directed tests for the AHB matrix output stage.
  Inputs change on the falling edge and outputs are checked there too.
  Every test starts from a fresh reset, so port 1 wins first.
*/
`timescale 1ns/100ps
`include "ahb_mtx_settings.svh"

module tb_output_stage;

  localparam int NUM_TESTS  = 6;
  localparam int CYC_PER_T  = 20;
  localparam int TIMEOUT_NS = (NUM_TESTS * CYC_PER_T + 40) * 10;  // Margin for resets

  logic                   HCLK;
  logic                   HRESETn;
  logic                   sel [1:3];
  logic [`AHB_ADDR_W-1:0] addr [1:3];
  ahb_pkg::htrans_t       trans [1:3];
  logic                   write [1:3];
  logic                   lock [1:3];
  ahb_pkg::wdata_t        wdata [1:3];
  logic                   held [1:3];
  logic                   hreadyout;
  logic                   act1, act2, act3;
  logic                   hselm, hwritem, hmastlockm, hreadymuxm;
  logic [`AHB_ADDR_W-1:0] haddrm;
  ahb_pkg::htrans_t       htransm;
  ahb_pkg::hsize_t        hsizem;
  ahb_pkg::hburst_t       hburstm;
  logic [3:0]             hprotm, hmasterm;
  ahb_pkg::wdata_t        hwdatam;
  int                     errors;
  int                     checks;
  int                     seed;

  ahb_mtx_output_stage dut0
  (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .i_sel_op1 (sel[1]), .i_addr_op1 (addr[1]), .i_trans_op1 (trans[1]),
    .i_write_op1 (write[1]), .i_size_op1 (3'd2), .i_burst_op1 (3'd0),
    .i_prot_op1 (4'h3), .i_master_op1 (4'h1), .i_mastlock_op1 (lock[1]),
    .i_wdata_op1 (wdata[1]), .i_held_tran_op1 (held[1]),
    .i_sel_op2 (sel[2]), .i_addr_op2 (addr[2]), .i_trans_op2 (trans[2]),
    .i_write_op2 (write[2]), .i_size_op2 (3'd2), .i_burst_op2 (3'd1),
    .i_prot_op2 (4'h3), .i_master_op2 (4'h2), .i_mastlock_op2 (lock[2]),
    .i_wdata_op2 (wdata[2]), .i_held_tran_op2 (held[2]),
    .i_sel_op3 (sel[3]), .i_addr_op3 (addr[3]), .i_trans_op3 (trans[3]),
    .i_write_op3 (write[3]), .i_size_op3 (3'd2), .i_burst_op3 (3'd0),
    .i_prot_op3 (4'h3), .i_master_op3 (4'h3), .i_mastlock_op3 (lock[3]),
    .i_wdata_op3 (wdata[3]), .i_held_tran_op3 (held[3]),
    .i_hreadyoutm (hreadyout),
    .o_active_op1 (act1), .o_active_op2 (act2), .o_active_op3 (act3),
    .o_hselm (hselm), .o_haddrm (haddrm), .o_htransm (htransm),
    .o_hwritem (hwritem), .o_hsizem (hsizem), .o_hburstm (hburstm),
    .o_hprotm (hprotm), .o_hmasterm (hmasterm), .o_hmastlockm (hmastlockm),
    .o_hreadymuxm (hreadymuxm), .o_hwdatam (hwdatam)
  );

  always #5 HCLK = ~HCLK;                 // 10 ns period

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // Expected owner as a port number where 0 means nobody
  task automatic compare_owner(input int port);
    compare_value("o_active_op1", 32'(act1), 32'(port == 1));
    compare_value("o_active_op2", 32'(act2), 32'(port == 2));
    compare_value("o_active_op3", 32'(act3), 32'(port == 3));
  endtask

  task automatic drive_port(input int p, input logic s, input logic h,
                            input ahb_pkg::htrans_t t, input logic lk);
    sel[p]   = s;
    held[p]  = h;
    trans[p] = t;
    lock[p]  = lk;
  endtask

  task automatic clear_ports();
    for (int p = 1; p <= 3; p++)
    begin
      drive_port(p, 1'b0, 1'b0, ahb_pkg::IDLE, 1'b0);
      addr[p]  = $random(seed);
      wdata[p] = $random(seed);
      write[p] = 1'b1;
    end
  endtask

  task automatic apply_reset();
    @(negedge HCLK);
    HRESETn   = 1'b0;
    hreadyout = 1'b1;
    clear_ports();
    repeat (5) @(negedge HCLK);
    HRESETn = 1'b1;
    @(negedge HCLK);
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic reset_values_test();
    apply_reset();
    compare_owner(0);
    compare_value("o_hselm", 32'(hselm), 32'h0);
    compare_value("o_hreadymuxm", 32'(hreadymuxm), 32'h1);
    compare_value("o_hwdatam", hwdatam, 32'h0);
  endtask

  task automatic single_write_test();
    apply_reset();
    drive_port(2, 1'b1, 1'b1, ahb_pkg::NONSEQ, 1'b0);
    @(negedge HCLK);                      // Granted at the edge before
    compare_owner(2);
    compare_value("o_hselm", 32'(hselm), 32'h1);
    compare_value("o_haddrm", haddrm, addr[2]);
    compare_value("o_htransm", 32'(htransm), 32'(ahb_pkg::NONSEQ));
    compare_value("o_hwritem", 32'(hwritem), 32'h1);
    compare_value("o_hmasterm", 32'(hmasterm), 32'h2);
    compare_value("o_hburstm", 32'(hburstm), 32'h1);
    compare_value("o_hsizem", 32'(hsizem), 32'h2);
    compare_value("o_hprotm", 32'(hprotm), 32'h3);
    compare_value("o_hmastlockm", 32'(hmastlockm), 32'h0);
    drive_port(2, 1'b0, 1'b0, ahb_pkg::IDLE, 1'b0);
    @(negedge HCLK);
    compare_value("o_hwdatam", hwdatam, wdata[2]);
    compare_owner(0);
  endtask

  task automatic round_robin_test();
    int exp_order [4];
    exp_order = '{1, 2, 3, 1};
    apply_reset();
    for (int p = 1; p <= 3; p++)
      drive_port(p, 1'b1, 1'b1, ahb_pkg::NONSEQ, 1'b0);
    for (int i = 0; i < 4; i++)
    begin
      @(negedge HCLK);
      compare_owner(exp_order[i]);
    end
  endtask

  task automatic burst_hold_test();
    apply_reset();
    drive_port(2, 1'b1, 1'b1, ahb_pkg::NONSEQ, 1'b0);
    @(negedge HCLK);
    compare_owner(2);
    drive_port(1, 1'b1, 1'b1, ahb_pkg::NONSEQ, 1'b0);  // Port 1 waits
    drive_port(2, 1'b1, 1'b1, ahb_pkg::SEQ, 1'b0);
    repeat (3)
    begin
      @(negedge HCLK);
      compare_owner(2);                   // SEQ keeps the slave
    end
    drive_port(2, 1'b0, 1'b0, ahb_pkg::IDLE, 1'b0);
    @(negedge HCLK);
    compare_owner(1);
  endtask

  task automatic lock_hold_test();
    apply_reset();
    drive_port(3, 1'b1, 1'b1, ahb_pkg::NONSEQ, 1'b1);
    @(negedge HCLK);
    compare_owner(3);
    compare_value("o_hmastlockm", 32'(hmastlockm), 32'h1);
    drive_port(1, 1'b1, 1'b1, ahb_pkg::NONSEQ, 1'b0);
    @(negedge HCLK);                      // Locked beat accepted
    compare_owner(3);
    drive_port(3, 1'b0, 1'b0, ahb_pkg::IDLE, 1'b1);  // Addresses elsewhere while locked
    @(negedge HCLK);
    compare_owner(3);
    compare_value("o_hselm", 32'(hselm), 32'h0);
    @(negedge HCLK);
    compare_owner(3);
    drive_port(3, 1'b0, 1'b0, ahb_pkg::IDLE, 1'b0);
    @(negedge HCLK);
    compare_owner(1);
  endtask

  task automatic back_pressure_test();
    apply_reset();
    drive_port(1, 1'b1, 1'b1, ahb_pkg::NONSEQ, 1'b0);
    @(negedge HCLK);
    compare_owner(1);
    drive_port(1, 1'b1, 1'b1, ahb_pkg::NONSEQ, 1'b0);  // Port 1 keeps asking
    drive_port(2, 1'b1, 1'b1, ahb_pkg::NONSEQ, 1'b0);
    hreadyout = 1'b0;
    repeat (3)
    begin
      @(negedge HCLK);
      compare_value("o_hreadymuxm", 32'(hreadymuxm), 32'h0);
      compare_owner(2);
      compare_value("o_hwdatam", hwdatam, wdata[1]);
    end
    hreadyout = 1'b1;
    drive_port(2, 1'b1, 1'b0, ahb_pkg::NONSEQ, 1'b0);
    @(negedge HCLK);
    compare_value("o_hreadymuxm", 32'(hreadymuxm), 32'h1);
    compare_owner(1);                     // Rotation moves on to port 1
    compare_value("o_hwdatam", hwdatam, wdata[2]);
  endtask

  // ----------------------------------------
  // Main sequence and watchdog
  // ----------------------------------------
  initial
  begin
    HCLK      = 1'b0;
    HRESETn   = 1'b0;
    hreadyout = 1'b1;
    errors    = 0;
    checks    = 0;
    seed      = 32'h73bff9a3;
    clear_ports();
    reset_values_test();
    single_write_test();
    round_robin_test();
    burst_hold_test();
    lock_hold_test();
    back_pressure_test();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    #(TIMEOUT_NS);
    $display("Timeout: the tests did not finish in the allowed time");
    $display("Test failed");
    $finish;
  end

endmodule
